/* files.f */
source/gunfight_pkg.sv
source/key_mapper.sv
source/tone_channel.sv
source/audio_mixer.sv
source/sigma_delta_dac.sv
source/gunfight_io_top.sv
verification/gunfight_io_props.sv
verification/tb_gunfight_io.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_gunfight_io \
	-f files.f \
	-o sim_gunfight_io

./obj_dir/sim_gunfight_io > sim.log 2>&1
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* verification/tb_gunfight_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gunfight_io;

	localparam int unsigned TONE_DIV    = 4;
	localparam int unsigned STEP        = 36; // Amplitude per volume unit
	localparam int unsigned N_KEYS      = 200;
	localparam int unsigned N_TONE      = 4;
	localparam int unsigned N_MIX       = 6;
	localparam int unsigned N_SAT       = 3;
	localparam int unsigned MIX_CYCLES  = 150;
	localparam int unsigned SETTLE      = 2 * 8 * TONE_DIV + 4;
	localparam int unsigned MAX_PERIOD  = 2 * 8 * TONE_DIV + 4;
	localparam int unsigned MAX_WINDOW  = 2 * 56 * TONE_DIV + 4; // Pitches 6 and 7
	localparam int unsigned CYCLE_LIMIT = 10 + N_KEYS * 5 + N_TONE * (1 + SETTLE + 3 * MAX_PERIOD)
		+ N_MIX * (5 + MIX_CYCLES) + N_SAT * (1 + SETTLE + MAX_WINDOW) + 200;

	logic                                clk_sys = 1'b0;
	logic                                arst_n;
	logic                                key_strobe;
	logic                                key_pressed;
	logic [7:0]                          key_code;
	logic [gunfight_pkg::CTRL_W-1:0]     sound_ctrl_a;
	logic [gunfight_pkg::CTRL_W-1:0]     sound_ctrl_b;
	logic                                coin;
	logic                                start_one;
	logic                                start_two;
	logic                                gun1_up;
	logic                                gun1_down;
	logic                                gun2_up;
	logic                                gun2_down;
	logic [gunfight_pkg::SAMPLE_W-1:0]   audio_sample;
	logic                                audio_pdm;

	logic [31:0] lfsr_state  = 32'h313480c0;
	logic [6:0]  model_keys  = '0; // coin down to gun2_down
	logic [8:0]  model_acc   = '0;
	logic [7:0]  prev_sample = '0;
	logic        arst_q      = 1'b0;
	int unsigned cycle_count = 0;
	int unsigned check_count = 0;
	int unsigned error_count = 0;
	logic [7:0]  mapped_codes [0:6];

	gunfight_io_top #(
		.TONE_DIV (TONE_DIV)
	) u_dut (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_code     (key_code),
		.sound_ctrl_a (sound_ctrl_a),
		.sound_ctrl_b (sound_ctrl_b),
		.coin         (coin),
		.start_one    (start_one),
		.start_two    (start_two),
		.gun1_up      (gun1_up),
		.gun1_down    (gun1_down),
		.gun2_up      (gun2_up),
		.gun2_down    (gun2_down),
		.audio_sample (audio_sample),
		.audio_pdm    (audio_pdm)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		arst_q = arst_n; // Reset as the DUT saw it on this edge
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int unsigned count);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int unsigned k = 0; k < count; k++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value      = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic int unsigned gcd(input int unsigned x, input int unsigned y);
		int unsigned t;
		while (y != 0) begin
			t = y;
			y = x % y;
			x = t;
		end
		return x;
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	// One falling edge, with the DAC model stepped alongside
	task automatic step_cycle();
		@(negedge clk_sys);
		if (!arst_q) begin
			model_acc = '0;
			check_equal(32'({coin, start_one, start_two, gun1_up, gun1_down, gun2_up, gun2_down,
				audio_sample, audio_pdm}), 32'd0, "outputs during reset");
		end else begin
			model_acc = {1'b0, model_acc[7:0]} + {1'b0, prev_sample};
			check_equal(32'(audio_pdm), 32'(model_acc[8]), "audio_pdm against accumulator model");
		end
		prev_sample = audio_sample;
	endtask

	task automatic model_key(input logic [7:0] code, input logic pressed);
		case (code)
			gunfight_pkg::KEY_ESC:  model_keys[6] = pressed;
			gunfight_pkg::KEY_F1:   model_keys[5] = pressed;
			gunfight_pkg::KEY_F2:   model_keys[4] = pressed;
			gunfight_pkg::KEY_Q:    model_keys[3] = pressed;
			gunfight_pkg::KEY_Y:    model_keys[2] = pressed;
			gunfight_pkg::KEY_UP:   model_keys[1] = pressed;
			gunfight_pkg::KEY_DOWN: model_keys[0] = pressed;
			default: ;
		endcase
	endtask

	task automatic check_controls(input string where);
		check_equal(32'({coin, start_one, start_two, gun1_up, gun1_down, gun2_up, gun2_down}),
			32'(model_keys), where);
	endtask

	task automatic wait_rise(output int unsigned waited);
		logic [7:0] last;
		logic       rose;
		last   = audio_sample;
		rose   = 1'b0;
		waited = 0;
		while (!rose && waited < MAX_PERIOD) begin
			step_cycle();
			waited++;
			rose = (audio_sample > last);
			last = audio_sample;
		end
		if (!rose) begin
			error_count++;
			$display("No rising step of audio_sample within %0d cycles at %0t", MAX_PERIOD, $time);
		end
	endtask

	initial begin
		int unsigned idle;
		int unsigned period;
		int unsigned waited;
		int unsigned amp_a;
		int unsigned amp_b;
		int unsigned sum_ab;
		int unsigned window;
		logic [7:0]  code;
		logic        pressed;
		logic [2:0]  pitch_a;
		logic [2:0]  pitch_b;
		logic [2:0]  vol_a;
		logic        in_set;
		logic        seen_full;
		arst_n       = 1'b0;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_code     = '0;
		sound_ctrl_a = '0;
		sound_ctrl_b = '0;
		mapped_codes[0] = gunfight_pkg::KEY_ESC;
		mapped_codes[1] = gunfight_pkg::KEY_F1;
		mapped_codes[2] = gunfight_pkg::KEY_F2;
		mapped_codes[3] = gunfight_pkg::KEY_Q;
		mapped_codes[4] = gunfight_pkg::KEY_Y;
		mapped_codes[5] = gunfight_pkg::KEY_UP;
		mapped_codes[6] = gunfight_pkg::KEY_DOWN;

		repeat (8) step_cycle();
		arst_n = 1'b1;
		step_cycle();
		check_controls("controls after reset");
		check_equal(32'(audio_sample), 32'd0, "audio_sample after reset");
		check_equal(32'(audio_pdm), 32'd0, "audio_pdm after reset");

		for (int i = 0; i < N_KEYS; i++) begin
			if (rand_bits(1) != 0)
				code = mapped_codes[rand_bits(3) % 7];
			else
				code = 8'(rand_bits(8)); // Mostly unmapped
			pressed     = rand_bits(1) != 0;
			key_code    = code;
			key_pressed = pressed;
			key_strobe  = 1'b1;
			model_key(code, pressed);
			step_cycle();
			key_strobe  = 1'b0;
			key_pressed = !pressed; // Ignored while strobe is low
			check_controls($sformatf("controls after code %02h", code));
			idle = rand_bits(2);
			repeat (idle) begin
				step_cycle();
				check_controls("controls between events");
			end
		end

		for (int i = 0; i < N_TONE; i++) begin
			pitch_a = 3'(rand_bits(3));
			vol_a   = 3'(rand_bits(3));
			if (vol_a == 3'd0)
				vol_a = 3'd1;
			sound_ctrl_a = {vol_a, pitch_a};
			sound_ctrl_b = '0;
			period       = 2 * (int'(pitch_a) + 1) * TONE_DIV;
			repeat (SETTLE) step_cycle();
			wait_rise(waited); // Align to a rising step
			for (int j = 0; j < 2; j++) begin
				wait_rise(waited);
				check_equal(waited, period, $sformatf("tone period for pitch %0d", pitch_a));
				check_equal(32'(audio_sample), 32'(vol_a) * STEP, "tone high level");
			end
		end

		for (int i = 0; i < N_MIX; i++) begin
			sound_ctrl_a = 6'(rand_bits(6));
			sound_ctrl_b = 6'(rand_bits(6));
			amp_a  = 32'(sound_ctrl_a[5:3]) * STEP;
			amp_b  = 32'(sound_ctrl_b[5:3]) * STEP;
			sum_ab = (amp_a + amp_b > 255) ? 255 : amp_a + amp_b;
			repeat (4) step_cycle();
			for (int j = 0; j < MIX_CYCLES; j++) begin
				step_cycle();
				in_set = (audio_sample == 8'd0) || (32'(audio_sample) == amp_a)
					|| (32'(audio_sample) == amp_b) || (32'(audio_sample) == sum_ab);
				check_equal(32'(in_set), 32'd1, $sformatf("sample %0d not in {0,%0d,%0d,%0d}",
					audio_sample, amp_a, amp_b, sum_ab));
			end
		end

		for (int i = 0; i < N_SAT; i++) begin
			pitch_a = 3'(rand_bits(3));
			pitch_b = 3'(rand_bits(3));
			if (pitch_b == pitch_a)
				pitch_b = pitch_a + 3'd1;
			sound_ctrl_a = {3'd7, pitch_a};
			sound_ctrl_b = {3'd7, pitch_b};
			period = (2 * (int'(pitch_a) + 1)) * (2 * (int'(pitch_b) + 1))
				/ gcd(2 * (int'(pitch_a) + 1), 2 * (int'(pitch_b) + 1));
			window    = period * TONE_DIV + 4; // One common period in cycles
			seen_full = 1'b0;
			repeat (SETTLE) step_cycle();
			for (int unsigned j = 0; j < window; j++) begin
				step_cycle();
				in_set = (audio_sample == 8'd0) || (audio_sample == 8'd252)
					|| (audio_sample == 8'd255);
				check_equal(32'(in_set), 32'd1, $sformatf("saturated mix gave %0d", audio_sample));
				if (audio_sample == 8'd255)
					seen_full = 1'b1;
			end
			check_equal(32'(seen_full), 32'd1, "full scale within one common period");
		end

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/gunfight_io_props.sv */
`timescale 1ns/1ps
`default_nettype none

module gunfight_io_props (
	input wire logic                              clk_sys,
	input wire logic                              arst_n,
	input wire logic                              key_strobe,
	input wire logic                              coin,
	input wire logic                              start_one,
	input wire logic                              start_two,
	input wire logic                              gun1_up,
	input wire logic                              gun1_down,
	input wire logic                              gun2_up,
	input wire logic                              gun2_down,
	input wire logic [gunfight_pkg::SAMPLE_W-1:0] level_a,
	input wire logic [gunfight_pkg::SAMPLE_W-1:0] level_b,
	input wire logic [gunfight_pkg::SAMPLE_W-1:0] audio_sample,
	input wire logic                              audio_pdm
);

	logic [6:0] controls;

	assign controls = {coin, start_one, start_two, gun1_up, gun1_down, gun2_up, gun2_down};

	// Mixer output moves only after a channel level moved
	sample_follows_levels: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(audio_sample) |-> ($past(level_a, 2) != $past(level_a))
			|| ($past(level_b, 2) != $past(level_b)))
		else $error("audio_sample changed without a channel level change");

	controls_need_strobe: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(controls) |-> $past(key_strobe))
		else $error("control level changed without a key strobe");

	outputs_zero_in_reset: assert property (@(posedge clk_sys)
		!arst_n |-> (controls == 7'd0 && audio_sample == '0 && audio_pdm == 1'b0))
		else $error("output not zero during reset");

endmodule

bind gunfight_io_top gunfight_io_props u_props (
	.clk_sys      (clk_sys),
	.arst_n       (arst_n),
	.key_strobe   (key_strobe),
	.coin         (coin),
	.start_one    (start_one),
	.start_two    (start_two),
	.gun1_up      (gun1_up),
	.gun1_down    (gun1_down),
	.gun2_up      (gun2_up),
	.gun2_down    (gun2_down),
	.level_a      (level_a),
	.level_b      (level_b),
	.audio_sample (audio_sample),
	.audio_pdm    (audio_pdm)
);

`default_nettype wire

/* source/gunfight_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gunfight_io_top #(
	parameter int unsigned TONE_DIV = 4
) (
	input  wire logic                              clk_sys,
	input  wire logic                              arst_n,
	input  wire logic                              key_strobe,
	input  wire logic                              key_pressed,
	input  wire logic [7:0]                        key_code,
	input  wire logic [gunfight_pkg::CTRL_W-1:0]   sound_ctrl_a,
	input  wire logic [gunfight_pkg::CTRL_W-1:0]   sound_ctrl_b,
	output logic                                   coin,
	output logic                                   start_one,
	output logic                                   start_two,
	output logic                                   gun1_up,
	output logic                                   gun1_down,
	output logic                                   gun2_up,
	output logic                                   gun2_down,
	output logic      [gunfight_pkg::SAMPLE_W-1:0] audio_sample,
	output logic                                   audio_pdm
);

	logic [gunfight_pkg::SAMPLE_W-1:0] level_a;
	logic [gunfight_pkg::SAMPLE_W-1:0] level_b;

	key_mapper u_key_mapper (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.coin        (coin),
		.start_one   (start_one),
		.start_two   (start_two),
		.gun1_up     (gun1_up),
		.gun1_down   (gun1_down),
		.gun2_up     (gun2_up),
		.gun2_down   (gun2_down)
	);

	// One channel per sound control port
	tone_channel #(
		.TONE_DIV (TONE_DIV)
	) u_tone_a (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.sound_ctrl (sound_ctrl_a),
		.level      (level_a)
	);

	tone_channel #(
		.TONE_DIV (TONE_DIV)
	) u_tone_b (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.sound_ctrl (sound_ctrl_b),
		.level      (level_b)
	);

	audio_mixer u_mixer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.level_a (level_a),
		.level_b (level_b),
		.sample  (audio_sample)
	);

	sigma_delta_dac u_dac (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.sample  (audio_sample),
		.pdm     (audio_pdm)
	);

endmodule

`default_nettype wire

/* source/sigma_delta_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac (
	input  wire logic                              clk_sys,
	input  wire logic                              arst_n,
	input  wire logic [gunfight_pkg::SAMPLE_W-1:0] sample,
	output logic                                   pdm
);

	logic [gunfight_pkg::SAMPLE_W:0] acc;

	// Error feedback, carry is dropped from the next sum
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[gunfight_pkg::SAMPLE_W-1:0]} + {1'b0, sample};
	end

	assign pdm = acc[gunfight_pkg::SAMPLE_W]; // Density is sample/256

endmodule

`default_nettype wire

/* source/audio_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input  wire logic                              clk_sys,
	input  wire logic                              arst_n,
	input  wire logic [gunfight_pkg::SAMPLE_W-1:0] level_a,
	input  wire logic [gunfight_pkg::SAMPLE_W-1:0] level_b,
	output logic      [gunfight_pkg::SAMPLE_W-1:0] sample
);

	logic [gunfight_pkg::SAMPLE_W:0] sum; // Extra bit catches overflow

	assign sum = {1'b0, level_a} + {1'b0, level_b};

	// Clamp to full scale instead of wrapping
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			sample <= '0;
		else if (sum[gunfight_pkg::SAMPLE_W])
			sample <= '1;
		else
			sample <= sum[gunfight_pkg::SAMPLE_W-1:0];
	end

endmodule

`default_nettype wire

/* source/tone_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_channel #(
	parameter int unsigned TONE_DIV = 4
) (
	input  wire logic                                clk_sys,
	input  wire logic                                arst_n,
	input  wire logic [gunfight_pkg::CTRL_W-1:0]     sound_ctrl,
	output logic      [gunfight_pkg::SAMPLE_W-1:0]   level
);

	localparam int unsigned PRE_W = (TONE_DIV > 1) ? $clog2(TONE_DIV) : 1;

	logic [PRE_W-1:0]                    pre_cnt;
	logic                                tick;
	logic [gunfight_pkg::PITCH_W-1:0]    pitch;
	logic [gunfight_pkg::VOL_W-1:0]      volume;
	logic [gunfight_pkg::PITCH_W-1:0]    half_cnt;
	logic [gunfight_pkg::SAMPLE_W-1:0]   amp;
	gunfight_pkg::tone_phase_e           phase;

	assign pitch  = sound_ctrl[2:0];
	assign volume = sound_ctrl[5:3];
	assign tick   = (pre_cnt == PRE_W'(TONE_DIV - 1));
	assign amp    = gunfight_pkg::SAMPLE_W'(volume * gunfight_pkg::VOL_STEP);

	// Clock prescaler
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			pre_cnt <= '0;
		else if (tick)
			pre_cnt <= '0;
		else
			pre_cnt <= pre_cnt + 1'b1;
	end

	// Half period is pitch+1 ticks, live pitch compared each tick
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			half_cnt <= '0;
			phase    <= gunfight_pkg::PHASE_LOW;
		end else if (tick) begin
			if (half_cnt == pitch) begin
				half_cnt <= '0;
				phase    <= (phase == gunfight_pkg::PHASE_HIGH) ?
					gunfight_pkg::PHASE_LOW : gunfight_pkg::PHASE_HIGH;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// Output level lags phase by one cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			level <= '0;
		else
			level <= (phase == gunfight_pkg::PHASE_HIGH) ? amp : '0;
	end

endmodule

`default_nettype wire

/* source/key_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module key_mapper (
	input  wire logic       clk_sys,
	input  wire logic       arst_n,
	input  wire logic       key_strobe,
	input  wire logic       key_pressed,
	input  wire logic [7:0] key_code,
	output logic            coin,
	output logic            start_one,
	output logic            start_two,
	output logic            gun1_up,
	output logic            gun1_down,
	output logic            gun2_up,
	output logic            gun2_down
);

	// Each level holds until the next event for its key
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			coin      <= 1'b0;
			start_one <= 1'b0;
			start_two <= 1'b0;
			gun1_up   <= 1'b0;
			gun1_down <= 1'b0;
			gun2_up   <= 1'b0;
			gun2_down <= 1'b0;
		end else if (key_strobe) begin
			case (gunfight_pkg::key_code_e'(key_code))
				gunfight_pkg::KEY_ESC:  coin      <= key_pressed;
				gunfight_pkg::KEY_F1:   start_one <= key_pressed;
				gunfight_pkg::KEY_F2:   start_two <= key_pressed;
				gunfight_pkg::KEY_Q:    gun1_up   <= key_pressed;
				gunfight_pkg::KEY_Y:    gun1_down <= key_pressed;
				gunfight_pkg::KEY_UP:   gun2_up   <= key_pressed;
				gunfight_pkg::KEY_DOWN: gun2_down <= key_pressed;
				default: ; // Unmapped, ignore
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/gunfight_pkg.sv */
`default_nettype none

package gunfight_pkg;

	// Audio level and sample width
	localparam int unsigned SAMPLE_W = 8;

	// Sound control port, [2:0] pitch, [5:3] volume
	localparam int unsigned CTRL_W = 6;
	localparam int unsigned PITCH_W = 3;
	localparam int unsigned VOL_W = 3;

	// Amplitude per volume unit, 7 gives 252
	localparam int unsigned VOL_STEP = 36;

	// PS/2 set 2 scan codes used by the cabinet
	typedef enum logic [7:0] {
		KEY_F1   = 8'h05, // Start one
		KEY_F2   = 8'h06, // Start two
		KEY_Q    = 8'h15, // Gun 1 up
		KEY_Y    = 8'h35, // Gun 1 down
		KEY_DOWN = 8'h72, // Gun 2 down
		KEY_UP   = 8'h75, // Gun 2 up
		KEY_ESC  = 8'h76  // Coin
	} key_code_e;

	// Square wave state
	typedef enum logic {
		PHASE_LOW  = 1'b0,
		PHASE_HIGH = 1'b1
	} tone_phase_e;

endpackage

`default_nettype wire
